// File: rtl/s16b_pkg.sv
//**************************************
// Fixed 64 kB regions, mapper holds bases only
// Byte lane order everywhere is {upper, lower}
//**************************************
package s16b_pkg;

    typedef logic [23:1] addr_t;      // Word address, byte bit numbering
    typedef logic [15:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [2:0]  region_t;
    typedef logic [7:0]  active_t;    // One-hot region match
    typedef logic [17:0] rom_addr_t;  // {region, A16..A1}

    // Transaction class seen by the acknowledge sequencer
    typedef logic [1:0] acc_class_t;

    localparam acc_class_t CLS_IMM  = 2'd0;  // IO, mapper window, unmapped
    localparam acc_class_t CLS_FAST = 2'd1;  // Char, palette, object RAM
    localparam acc_class_t CLS_ROM  = 2'd2;
    localparam acc_class_t CLS_RAM  = 2'd3;  // Work RAM and VRAM share ram_ok

    // Mapper region numbers
    localparam region_t REG_ROM0 = 3'd0;
    localparam region_t REG_ROM1 = 3'd1;
    localparam region_t REG_ROM2 = 3'd2;
    localparam region_t REG_RAM  = 3'd3;
    localparam region_t REG_ORAM = 3'd4;
    localparam region_t REG_VRAM = 3'd5;
    localparam region_t REG_PAL  = 3'd6;
    localparam region_t REG_IO   = 3'd7;

    // Base byte (A23..A16) of each region after reset
    localparam byte_t MAP_RESET [0:7] = '{
        8'h00, 8'h01, 8'h02,                // ROM banks
        8'h10, 8'h11, 8'h12, 8'h13, 8'h14   // RAM, ORAM, VRAM, PAL, IO
    };

    // Open bus value
    localparam word_t UNMAPPED_DATA = 16'hFFFF;

endpackage

// File: rtl/s16b_mapper.sv
//**************************************
// Base registers only, region size fixed at 64 kB
// Mapper window page shadows any region on the same page
//**************************************
module s16b_mapper
    import s16b_pkg::*;
#(
    parameter byte_t MAP_PAGE = 8'h3F   // A23..A16 of the register window
) (
    input  logic    clk,
    input  logic    rst,
    input  addr_t   addr,
    input  word_t   wdata,
    input  logic    map_wr,
    output active_t active,
    output logic    map_hit
);

    byte_t   base [0:7];
    active_t match;
    region_t sel;

    assign sel = addr[3:1];   // Register index inside the window

    // Base registers, written through the window
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                base[i] <= MAP_RESET[i];
            end
        end else if (map_wr) begin
            base[sel] <= wdata[7:0];   // Only the low byte is kept
        end
    end

    // Window decode
    assign map_hit = (addr[23:16] == MAP_PAGE);

    // Every region compares its base against the page
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            match[i] = (addr[23:16] == base[i]);
        end
    end

    // Lowest matching index wins
    // Isolating the lowest set bit keeps the result one-hot
    always_comb begin
        if (map_hit) begin
            active = '0;
        end else begin
            active = match & (~match + 8'd1);
        end
    end

endmodule

// File: rtl/s16b_bus_ack.sv
//**************************************
// One transaction at a time, WAIT_MAX must be 3 or more
//**************************************
module s16b_bus_ack
    import s16b_pkg::*;
#(
    parameter int WAIT_MAX = 32    // Cycles from accept to forced response
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  acc_class_t acc_class,
    input  logic       rom_ok,
    input  logic       ram_ok,
    input  logic       rsp_ready,
    output logic       busy,
    output logic       finish,
    output logic       timeout,
    output logic       rsp_valid
);

    localparam int CW = $clog2(WAIT_MAX + 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_RESP
    } state_t;

    state_t        state;
    logic [CW-1:0] cnt;       // Cycles since the accept edge
    logic          done_ok;

    // Completion per class, cnt 0 is the decode cycle
    always_comb begin
        case (acc_class)
            CLS_IMM:  done_ok = (cnt == CW'(1));
            CLS_FAST: done_ok = (cnt == CW'(2));   // Data valid on 2nd cs cycle
            CLS_ROM:  done_ok = rom_ok && (cnt != '0);
            default:  done_ok = ram_ok && (cnt != '0);
        endcase
    end

    // Response lands on edge E0 + WAIT_MAX when nothing answers
    assign timeout = (state == ST_WAIT) && !done_ok && (cnt == CW'(WAIT_MAX - 1));
    assign finish  = (state == ST_WAIT) && (done_ok || timeout);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                ST_IDLE: if (start) begin
                    state <= ST_WAIT;
                    cnt   <= '0;
                end
                ST_WAIT: begin
                    cnt <= cnt + CW'(1);
                    if (finish) state <= ST_RESP;
                end
                default: if (rsp_ready) state <= ST_IDLE;  // Held until taken
            endcase
        end
    end

    assign busy      = (state != ST_IDLE);
    assign rsp_valid = (state == ST_RESP);

endmodule

// File: rtl/s16b_io_regs.sv
//**************************************
// Strobes come from registered chip selects
// cab_dout is FF unless io_rd is high
//**************************************
module s16b_io_regs
    import s16b_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  addr_t      addr,
    input  word_t      wdata,
    input  logic       lower_we,
    input  logic       io_wr,
    input  logic       io_rd,
    input  logic       tbank_wr,
    input  byte_t      joystick1,
    input  byte_t      joystick2,
    input  logic [1:0] start_button,
    input  logic [1:0] coin_input,
    input  logic       service,
    input  logic       dip_test,
    input  byte_t      dipsw_a,
    input  byte_t      dipsw_b,
    output byte_t      cab_dout,
    output logic       flip,
    output logic       video_en,
    output logic [5:0] tile_bank
);

    byte_t sort1;
    byte_t sort2;

    // Board wiring order of the joystick lines
    function automatic byte_t sort_joy(input byte_t joy);
        return {joy[1:0], joy[3:2], joy[7], joy[5:4], joy[6]};
    endfunction

    assign sort1 = sort_joy(joystick1);
    assign sort2 = sort_joy(joystick2);

    // Read side
    always_comb begin
        cab_dout = 8'hFF;
        if (io_rd) begin
            case (addr[13:12])
                2'd1: begin
                    case (addr[2:1])
                        2'd0: cab_dout = {2'b11, start_button, service, dip_test, coin_input};
                        2'd1: cab_dout = sort1;
                        2'd3: cab_dout = sort2;
                        default: cab_dout = 8'hFF;
                    endcase
                end
                2'd2: cab_dout = addr[1] ? dipsw_a : dipsw_b;
                default: cab_dout = 8'hFF;   // Video control reads open bus
            endcase
        end
    end

    // Video control, low byte only
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flip     <= 1'b0;
            video_en <= 1'b1;
        end else if (io_wr && lower_we && addr[13:12] == 2'd0) begin
            flip     <= wdata[6];
            video_en <= wdata[5];
        end
    end

    // Tile bank halves
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tile_bank <= '0;
        end else if (tbank_wr && lower_we) begin
            if (addr[1]) tile_bank[5:3] <= wdata[2:0];
            else         tile_bank[2:0] <= wdata[2:0];
        end
    end

endmodule

// File: rtl/s16b_main.sv
//**************************************
// Request fields are sampled once at accept
// Chip selects stay high until the response edge
//**************************************
module s16b_main
    import s16b_pkg::*;
#(
    parameter int    WAIT_MAX = 32,
    parameter byte_t MAP_PAGE = 8'h3F
) (
    input  logic       clk,
    input  logic       rst,
    // Request port
    input  logic       req_valid,
    output logic       req_ready,
    input  addr_t      req_addr,
    input  logic       req_we,
    input  logic [1:0] req_be,
    input  word_t      req_wdata,
    // Response port
    output logic       rsp_valid,
    input  logic       rsp_ready,
    output word_t      rsp_rdata,
    output logic       rsp_err,
    // ROM
    output logic       rom_cs,
    output rom_addr_t  rom_addr,
    input  word_t      rom_data,
    input  logic       rom_ok,
    // Work RAM and VRAM
    output logic       ram_cs,
    output logic       vram_cs,
    input  word_t      ram_data,
    input  logic       ram_ok,
    output addr_t      mem_addr,
    output word_t      mem_wdata,
    output logic [1:0] mem_be_n,
    output logic       mem_we,
    // Fast video memories
    output logic       char_cs,
    output logic       pal_cs,
    output logic       objram_cs,
    input  word_t      char_dout,
    input  word_t      pal_dout,
    input  word_t      obj_dout,
    // Cabinet
    input  byte_t      joystick1,
    input  byte_t      joystick2,
    input  logic [1:0] start_button,
    input  logic [1:0] coin_input,
    input  logic       service,
    input  logic       dip_test,
    input  byte_t      dipsw_a,
    input  byte_t      dipsw_b,
    output logic       flip,
    output logic       video_en,
    output logic [5:0] tile_bank
);

    addr_t      lat_addr;
    logic       lat_we;
    logic [1:0] lat_be;
    word_t      lat_wdata;
    logic       accept, dec_pend, busy, finish, timeout;
    logic       io_cs, map_cs, tbank_cs, rom_hit;
    active_t    active;
    logic       map_hit;
    acc_class_t acc_class;
    logic [1:0] rom_idx;
    byte_t      cab_dout;

    assign req_ready = !busy;
    assign accept    = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (accept) begin
            lat_addr  <= req_addr;
            lat_we    <= req_we;
            lat_be    <= req_be;
            lat_wdata <= req_wdata;
        end
    end

    assign rom_hit = |active[REG_ROM2:REG_ROM0];

    // Class follows the same decode as the chip selects
    always_comb begin
        if (rom_hit && !lat_we)
            acc_class = CLS_ROM;
        else if (active[REG_RAM] || (active[REG_VRAM] && !lat_addr[15]))
            acc_class = CLS_RAM;
        else if (active[REG_VRAM] || active[REG_PAL] || active[REG_ORAM])
            acc_class = CLS_FAST;
        else
            acc_class = CLS_IMM;
    end

    // Chip selects registered one cycle after accept
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec_pend  <= 1'b0;
            rom_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            vram_cs   <= 1'b0;
            char_cs   <= 1'b0;
            pal_cs    <= 1'b0;
            objram_cs <= 1'b0;
            io_cs     <= 1'b0;
            map_cs    <= 1'b0;
            tbank_cs  <= 1'b0;
        end else begin
            dec_pend <= accept;
            if (dec_pend) begin
                rom_cs    <= rom_hit && !lat_we;
                ram_cs    <= active[REG_RAM];
                vram_cs   <= active[REG_VRAM] && !lat_addr[15];
                char_cs   <= active[REG_VRAM] && lat_addr[15];  // Text RAM in upper half
                pal_cs    <= active[REG_PAL];
                objram_cs <= active[REG_ORAM];
                io_cs     <= active[REG_IO];
                map_cs    <= map_hit;
                tbank_cs  <= active[REG_ROM2] && lat_we;
            end else if (finish) begin
                rom_cs    <= 1'b0;
                ram_cs    <= 1'b0;
                vram_cs   <= 1'b0;
                char_cs   <= 1'b0;
                pal_cs    <= 1'b0;
                objram_cs <= 1'b0;
                io_cs     <= 1'b0;
                map_cs    <= 1'b0;
                tbank_cs  <= 1'b0;
            end
        end
    end

    // Active is one-hot so the encoding is a plain OR
    assign rom_idx   = {active[REG_ROM2], active[REG_ROM1]};
    assign rom_addr  = {rom_idx, lat_addr[16:1]};
    assign mem_addr  = lat_addr;
    assign mem_wdata = lat_wdata;
    assign mem_be_n  = ~lat_be;
    assign mem_we    = lat_we && (ram_cs || vram_cs);

    // Read data, captured on the finish edge
    always_ff @(posedge clk) begin
        if (finish) begin
            rsp_err <= timeout;
            if (timeout || lat_we) rsp_rdata <= UNMAPPED_DATA;
            else if (rom_cs)               rsp_rdata <= rom_data;
            else if (ram_cs || vram_cs)    rsp_rdata <= ram_data;
            else if (char_cs)              rsp_rdata <= char_dout;
            else if (pal_cs)               rsp_rdata <= pal_dout;
            else if (objram_cs)            rsp_rdata <= obj_dout;
            else if (io_cs)                rsp_rdata <= {8'hFF, cab_dout};
            else                           rsp_rdata <= UNMAPPED_DATA;
        end
    end

    s16b_mapper #(.MAP_PAGE(MAP_PAGE)) u_mapper (
        .clk     (clk),
        .rst     (rst),
        .addr    (lat_addr),
        .wdata   (lat_wdata),
        .map_wr  (map_cs && lat_we),
        .active  (active),
        .map_hit (map_hit)
    );

    s16b_bus_ack #(.WAIT_MAX(WAIT_MAX)) u_bus_ack (
        .clk       (clk),
        .rst       (rst),
        .start     (accept),
        .acc_class (acc_class),
        .rom_ok    (rom_ok),
        .ram_ok    (ram_ok),
        .rsp_ready (rsp_ready),
        .busy      (busy),
        .finish    (finish),
        .timeout   (timeout),
        .rsp_valid (rsp_valid)
    );

    s16b_io_regs u_io_regs (
        .clk          (clk),
        .rst          (rst),
        .addr         (lat_addr),
        .wdata        (lat_wdata),
        .lower_we     (lat_be[0]),
        .io_wr        (io_cs && lat_we),
        .io_rd        (io_cs && !lat_we),
        .tbank_wr     (tbank_cs),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .dip_test     (dip_test),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .cab_dout     (cab_dout),
        .flip         (flip),
        .video_en     (video_en),
        .tile_bank    (tile_bank)
    );

endmodule

// File: bench/s16b_main_chk.sv
//**************************************
// Bound into s16b_main, observes ports only
//**************************************
module s16b_main_chk
    import s16b_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input logic  req_ready,
    input logic  rsp_valid,
    input logic  rsp_ready,
    input word_t rsp_rdata,
    input logic  rsp_err,
    input logic  rom_cs,
    input logic  ram_cs,
    input logic  vram_cs,
    input logic  char_cs,
    input logic  pal_cs,
    input logic  objram_cs
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [5:0] cs_vec;

    assign cs_vec = {rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs};

    a_one_cs: assert property (@(posedge clk) disable iff (rst) $onehot0(cs_vec))
        else $error("More than one chip select high");

    a_ready_rsp: assert property (@(posedge clk) disable iff (rst) !(req_ready && rsp_valid))
        else $error("req_ready and rsp_valid high together");

    // Held response must not move
    a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_rdata) && $stable(rsp_err)))
        else $error("Response changed while held");

    a_reset_cs: assert property (@(posedge clk) rst |-> (cs_vec == '0))
        else $error("Chip select high during reset");

endmodule

// File: bench/s16b_main_tb.sv
//**************************************
// Must run from the project root to find bench/s16b_stimulus.txt
//**************************************
module s16b_main_tb
    import s16b_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_MAX = 32;

    logic       clk, rst;
    logic       req_valid, req_ready, req_we, rsp_valid, rsp_ready, rsp_err;
    addr_t      req_addr, mem_addr;
    logic [1:0] req_be, mem_be_n, start_button, coin_input;
    word_t      req_wdata, rsp_rdata, rom_data, ram_data, mem_wdata;
    word_t      char_dout, pal_dout, obj_dout;
    rom_addr_t  rom_addr;
    logic       rom_cs, rom_ok, ram_cs, vram_cs, ram_ok, mem_we;
    logic       char_cs, pal_cs, objram_cs, service, dip_test, flip, video_en;
    byte_t      joystick1, joystick2, dipsw_a, dipsw_b;
    logic [5:0] tile_bank;

    string       ops[$];
    logic [31:0] f_a[$], f_b[$], f_c[$], f_d[$], f_e[$];
    word_t       ram_mem [0:4095];
    int          cycles, limit, rom_wait, ram_wait;
    logic        rom_acked, ram_acked;
    logic        fast_held, fast_ready;

    s16b_main #(.WAIT_MAX(WAIT_MAX)) dut (.*);

    bind s16b_main s16b_main_chk u_chk (
        .clk(clk), .rst(rst), .req_ready(req_ready), .rsp_valid(rsp_valid),
        .rsp_ready(rsp_ready), .rsp_rdata(rsp_rdata), .rsp_err(rsp_err),
        .rom_cs(rom_cs), .ram_cs(ram_cs), .vram_cs(vram_cs), .char_cs(char_cs),
        .pal_cs(pal_cs), .objram_cs(objram_cs)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Memory models
    assign rom_data  = rom_addr[15:0] ^ 16'hA5A5;
    assign ram_data  = ram_mem[{vram_cs, mem_addr[11:1]}];

    // Fast video memories give data on the second cycle of their select
    always @(negedge clk) begin
        fast_ready = fast_held;
        fast_held  = char_cs || pal_cs || objram_cs;
    end

    assign char_dout = (char_cs && fast_ready) ? (mem_addr[16:1] ^ 16'h1111) : UNMAPPED_DATA;
    assign pal_dout  = (pal_cs && fast_ready) ? (mem_addr[16:1] ^ 16'h2222) : UNMAPPED_DATA;
    assign obj_dout  = (objram_cs && fast_ready) ? (mem_addr[16:1] ^ 16'h3333) : UNMAPPED_DATA;

    always @(negedge clk) begin
        rom_ok = 1'b0;
        if (!rom_cs) begin
            rom_acked = 1'b0;
            rom_wait  = $urandom % 7;
        end else if (!rom_acked) begin
            if (rom_wait == 0) begin
                rom_acked = 1'b1;
                rom_ok    = (rom_addr[17:16] != 2'd2);  // Bank 2 stays silent
            end else begin
                rom_wait--;
            end
        end
    end

    always @(negedge clk) begin
        ram_ok = 1'b0;
        if (!(ram_cs || vram_cs)) begin
            ram_acked = 1'b0;
            ram_wait  = $urandom % 7;
        end else if (!ram_acked) begin
            if (ram_wait == 0) begin
                ram_acked = 1'b1;
                ram_ok    = 1'b1;
                if (mem_we && !mem_be_n[1])
                    ram_mem[{vram_cs, mem_addr[11:1]}][15:8] = mem_wdata[15:8];
                if (mem_we && !mem_be_n[0])
                    ram_mem[{vram_cs, mem_addr[11:1]}][7:0] = mem_wdata[7:0];
            end else begin
                ram_wait--;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("Run stopped after %0d cycles without finishing", cycles);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    end

    task automatic compare(input string what, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic bus_xfer(input logic we, input logic [23:0] baddr, input word_t wd,
                            input logic [1:0] be, output word_t rd, output logic err);
        req_valid = 1'b1;
        req_we    = we;
        req_addr  = baddr[23:1];
        req_wdata = wd;
        req_be    = be;
        while (!req_ready) @(negedge clk);
        @(negedge clk);           // Accepted on the edge just passed
        req_valid = 1'b0;
        while (!(rsp_valid && rsp_ready)) begin
            rsp_ready = ($urandom % 3) != 0;
            if (!(rsp_valid && rsp_ready)) @(negedge clk);
        end
        rd  = rsp_rdata;
        err = rsp_err;
        @(negedge clk);
        rsp_ready = 1'b0;
    endtask

    task automatic set_input(input logic [31:0] field, input logic [31:0] value);
        case (field)
            0: joystick1 = value[7:0];
            1: joystick2 = value[7:0];
            2: start_button = value[1:0];
            3: coin_input = value[1:0];
            4: service = value[0];
            5: dip_test = value[0];
            6: dipsw_a = value[7:0];
            default: dipsw_b = value[7:0];
        endcase
    endtask

    initial begin
        int    fd, n;
        string line, op;
        logic [31:0] a, b, c, d, e;
        word_t rd;
        logic  err;
        void'($urandom(32'h5104a70c));
        $timeformat(-9, 0, " ns", 0);
        {rst, req_valid, req_we, rsp_ready, service, dip_test} = 6'b100000;
        req_addr = '0;
        req_be = 2'b00;
        req_wdata = '0;
        {start_button, coin_input} = 4'b0;
        {joystick1, joystick2, dipsw_a, dipsw_b} = 32'hFFFF_FFFF;
        {rom_ok, ram_ok, rom_acked, ram_acked} = 4'b0;
        {fast_held, fast_ready} = 2'b0;
        cycles = 0;
        limit = 0;
        for (int i = 0; i < 4096; i++) ram_mem[i] = 16'(i * 40503) ^ 16'h6C6C;
        fd = $fopen("bench/s16b_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file bench/s16b_stimulus.txt");
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) && line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%s %h %h %h %h %h", op, a, b, c, d, e);
                if (n == 6) begin
                    ops.push_back(op);
                    f_a.push_back(a);
                    f_b.push_back(b);
                    f_c.push_back(c);
                    f_d.push_back(d);
                    f_e.push_back(e);
                end
            end
        end
        $fclose(fd);
        limit = ops.size() * (WAIT_MAX + 20);
        foreach (ops[i]) begin
            @(negedge clk);
            case (ops[i])
                "X": begin
                    rst = 1'b1;
                    repeat (16) @(negedge clk);
                    rst = 1'b0;
                    compare("req_ready after reset", 16'(req_ready), 16'h1);
                    compare("chip selects after reset",
                            16'({rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs}), 16'h0);
                end
                "R", "W": begin
                    bus_xfer(ops[i] == "W", f_a[i][23:0], f_b[i][15:0], f_c[i][1:0], rd, err);
                    compare($sformatf("%s %h rdata", ops[i], f_a[i][23:0]), rd, f_d[i][15:0]);
                    compare($sformatf("%s %h err", ops[i], f_a[i][23:0]), 16'(err), f_e[i][15:0]);
                end
                "I": set_input(f_a[i], f_b[i]);
                "S": begin
                    compare("flip", 16'(flip), f_a[i][15:0]);
                    compare("video_en", 16'(video_en), f_b[i][15:0]);
                    compare("tile_bank", 16'(tile_bank), f_c[i][15:0]);
                end
                default: begin
                    $display("Unknown command %s in the stimulus file", ops[i]);
                    $display("TEST RESULT: FAIL");
                    $fatal(1);
                end
            endcase
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: bench/s16b_stimulus.txt
# op byte_addr wdata be exp_rdata exp_err   (all hex; op R read, W write)
# I field value 0 0 0 / S flip video_en tile_bank 0 0 / X reset 0 0 0 0 0
X 0 0 0 0 0
S 0 1 0 0 0
R 000100 0 3 A525 0
R 012468 0 3 3791 0
R 129000 0 3 5911 0
R 130A42 0 3 A703 0
R 11FFFE 0 3 CCCC 0
W 100040 1234 3 FFFF 0
W 100040 ABCD 1 FFFF 0
R 100040 0 3 12CD 0
W 100040 5678 2 FFFF 0
R 100040 0 3 56CD 0
W 100040 9999 0 FFFF 0
R 100040 0 3 56CD 0
W 120010 BEEF 3 FFFF 0
W 120010 0011 2 FFFF 0
R 120010 0 3 00EF 0
R 100040 0 3 56CD 0
W 3F0006 0020 3 FFFF 0
R 100040 0 3 FFFF 0
R 200040 0 3 56CD 0
W 3F0006 0010 3 FFFF 0
R 100040 0 3 56CD 0
I 0 5A 0 0 0
I 1 81 0 0 0
I 2 1 0 0 0
I 3 2 0 0 0
I 4 0 0 0 0
I 5 1 0 0 0
I 6 3C 0 0 0
I 7 C5 0 0 0
R 141000 0 3 FFD6 0
R 141002 0 3 FFA3 0
R 141006 0 3 FF48 0
R 141004 0 3 FFFF 0
R 142000 0 3 FFC5 0
R 142002 0 3 FF3C 0
W 140000 0040 1 FFFF 0
S 1 0 0 0 0
W 140000 0020 1 FFFF 0
W 140000 0040 2 FFFF 0
S 0 1 0 0 0
W 020002 0005 1 FFFF 0
W 020000 0003 3 FFFF 0
S 0 1 2B 0 0
R 020010 0 3 FFFF 1
R 000100 0 3 A525 0

// File: sources.f
rtl/s16b_pkg.sv
rtl/s16b_mapper.sv
rtl/s16b_bus_ack.sv
rtl/s16b_io_regs.sv
rtl/s16b_main.sv
bench/s16b_main_chk.sv
bench/s16b_main_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the s16b_main testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/1ps \
    --top-module s16b_main_tb \
    -f sources.f \
    -o s16b_sim \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/s16b_sim 2>&1 | tee sim.log

grep -q "TEST RESULT: FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation ended without a result"; exit 1; }
